//--- hdl/dab_pkg.sv
// DAB modulator shared definitions
// Bus widths, register map and the power-up configuration sequence

package dab_pkg;

    // Write bus and timing value types
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] duty_t;

    // Register map, bit 0 of the control register enables the timebase
    localparam addr_t ADDR_CONTROL   = 16'h000;
    localparam addr_t ADDR_PERIOD    = 16'h004;
    localparam addr_t ADDR_DEAD_TIME = 16'h008;
    localparam addr_t ADDR_DUTY_1    = 16'h010;
    localparam addr_t ADDR_PHASE_1   = 16'h014;
    localparam addr_t ADDR_DUTY_2    = 16'h018;
    localparam addr_t ADDR_PHASE_2   = 16'h01C;

    // Default operating point in clock cycles
    localparam duty_t DEFAULT_PERIOD    = 16'd100;
    localparam duty_t DEFAULT_DEAD_TIME = 16'd4;
    localparam duty_t DEFAULT_DUTY      = 16'd50;

    // Configuration sequence, the timebase is switched on last
    localparam int CONFIG_WRITES = 3;

    localparam addr_t CONFIG_ADDR [CONFIG_WRITES] = '{
        ADDR_PERIOD,
        ADDR_DEAD_TIME,
        ADDR_CONTROL
    };

    localparam data_t CONFIG_DATA [CONFIG_WRITES] = '{
        data_t'(DEFAULT_PERIOD),
        data_t'(DEFAULT_DEAD_TIME),
        32'h0000_0001
    };

endpackage

//--- hdl/dab_pre_modulation_processor.sv
// DAB pre-modulation processor
// Turns a configure strobe or a per-field update mask into a sequence of
// register writes on the write bus and pulses done after the last one
`timescale 1ns/1ps

module dab_pre_modulation_processor (
    input  logic            clock,
    input  logic            reset,
    input  logic            configure,
    input  logic [3:0]      update,
    input  dab_pkg::duty_t  duty_1,
    input  dab_pkg::duty_t  duty_2,
    input  dab_pkg::duty_t  phase_shift_1,
    input  dab_pkg::duty_t  phase_shift_2,
    input  logic            write_ready,
    output logic            done,
    output logic            write_valid,
    output dab_pkg::addr_t  write_dest,
    output dab_pkg::data_t  write_data
);

    typedef enum logic [1:0] {
        state_idle,
        state_issue,
        state_strobe
    } state_t;

    state_t          state;
    logic            configuring;
    logic [1:0]      config_index;
    logic            last_config;
    logic            request;
    logic [3:0]      pending;
    logic [3:0]      pick;
    dab_pkg::addr_t  update_dest;
    dab_pkg::data_t  update_data;
    dab_pkg::duty_t  duty_1_q;
    dab_pkg::duty_t  duty_2_q;
    dab_pkg::duty_t  phase_1_q;
    dab_pkg::duty_t  phase_2_q;

    assign request     = configure || (update != 4'b0000);
    assign last_config = config_index == 2'(dab_pkg::CONFIG_WRITES - 1);

    // Lowest pending mask bit goes first
    // Bit 0 is duty 1, bit 1 duty 2, bit 2 phase 1 and bit 3 phase 2
    assign pick = pending & (~pending + 4'd1);

    always_comb begin
        update_dest = dab_pkg::ADDR_PHASE_2;
        update_data = dab_pkg::data_t'(phase_2_q);
        if (pick[0]) begin
            update_dest = dab_pkg::ADDR_DUTY_1;
            update_data = dab_pkg::data_t'(duty_1_q);
        end else if (pick[1]) begin
            update_dest = dab_pkg::ADDR_DUTY_2;
            update_data = dab_pkg::data_t'(duty_2_q);
        end else if (pick[2]) begin
            update_dest = dab_pkg::ADDR_PHASE_1;
            update_data = dab_pkg::data_t'(phase_1_q);
        end
    end

    // Sequencing FSM
    // Issue waits for ready, strobe waits for the slave to drop ready
    always_ff @(posedge clock) begin
        if (!reset) begin
            state        <= state_idle;
            done         <= 1'b0;
            write_valid  <= 1'b0;
            configuring  <= 1'b0;
            config_index <= 2'd0;
            pending      <= 4'b0000;
        end else begin
            done <= 1'b0;
            case (state)
                state_idle: begin
                    if (configure) begin
                        configuring  <= 1'b1;
                        config_index <= 2'd0;
                        state        <= state_issue;
                    end else if (update != 4'b0000) begin
                        configuring <= 1'b0;
                        pending     <= update;
                        state       <= state_issue;
                    end
                end
                state_issue: begin
                    if (write_ready) begin
                        write_valid <= 1'b1;
                        if (!configuring) begin
                            pending <= pending & ~pick;
                        end
                        state <= state_strobe;
                    end
                end
                state_strobe: begin
                    write_valid <= 1'b0;
                    if (!write_ready) begin
                        if (configuring ? last_config : (pending == 4'b0000)) begin
                            done  <= 1'b1;
                            state <= state_idle;
                        end else begin
                            if (configuring) begin
                                config_index <= config_index + 2'd1;
                            end
                            state <= state_issue;
                        end
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Request values are frozen when the sequence starts
    always_ff @(posedge clock) begin
        if (state == state_idle && request) begin
            duty_1_q  <= duty_1;
            duty_2_q  <= duty_2;
            phase_1_q <= phase_shift_1;
            phase_2_q <= phase_shift_2;
        end
        if (state == state_issue && write_ready) begin
            if (configuring) begin
                write_dest <= dab_pkg::CONFIG_ADDR[config_index];
                write_data <= dab_pkg::CONFIG_DATA[config_index];
            end else begin
                write_dest <= update_dest;
                write_data <= update_data;
            end
        end
    end

endmodule

//--- hdl/modulator_register_file.sv
// Modulator register file
// Write bus slave with shadow registers that move to the active set at
// period boundaries while the timebase runs
`timescale 1ns/1ps

module modulator_register_file (
    input  logic            clock,
    input  logic            reset,
    input  logic            write_valid,
    input  dab_pkg::addr_t  write_dest,
    input  dab_pkg::data_t  write_data,
    input  logic            period_end,
    output logic            write_ready,
    output logic            enable,
    output dab_pkg::duty_t  period,
    output dab_pkg::duty_t  dead_time,
    output dab_pkg::duty_t  duty_1,
    output dab_pkg::duty_t  phase_1,
    output dab_pkg::duty_t  duty_2,
    output dab_pkg::duty_t  phase_2
);

    logic            enable_shadow;
    dab_pkg::duty_t  period_shadow;
    dab_pkg::duty_t  dead_time_shadow;
    dab_pkg::duty_t  duty_1_shadow;
    dab_pkg::duty_t  phase_1_shadow;
    dab_pkg::duty_t  duty_2_shadow;
    dab_pkg::duty_t  phase_2_shadow;
    logic            load;

    // Stopped timebase lets new values through at once
    assign load = !enable || period_end;

    // Ready drops for the single cycle after each accepted write
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ready <= 1'b1;
        end else begin
            write_ready <= !write_valid;
        end
    end

    // Period resets to zero so both legs stay off until configured
    // Dead time also starts at zero and is set by the configuration sequence
    always_ff @(posedge clock) begin
        if (!reset) begin
            enable_shadow    <= 1'b0;
            period_shadow    <= '0;
            dead_time_shadow <= '0;
            duty_1_shadow    <= dab_pkg::DEFAULT_DUTY;
            phase_1_shadow   <= '0;
            duty_2_shadow    <= dab_pkg::DEFAULT_DUTY;
            phase_2_shadow   <= '0;
        end else if (write_valid) begin
            case (write_dest)
                dab_pkg::ADDR_CONTROL:   enable_shadow    <= write_data[0];
                dab_pkg::ADDR_PERIOD:    period_shadow    <= dab_pkg::duty_t'(write_data);
                dab_pkg::ADDR_DEAD_TIME: dead_time_shadow <= dab_pkg::duty_t'(write_data);
                dab_pkg::ADDR_DUTY_1:    duty_1_shadow    <= dab_pkg::duty_t'(write_data);
                dab_pkg::ADDR_PHASE_1:   phase_1_shadow   <= dab_pkg::duty_t'(write_data);
                dab_pkg::ADDR_DUTY_2:    duty_2_shadow    <= dab_pkg::duty_t'(write_data);
                dab_pkg::ADDR_PHASE_2:   phase_2_shadow   <= dab_pkg::duty_t'(write_data);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable    <= 1'b0;
            period    <= '0;
            dead_time <= '0;
            duty_1    <= dab_pkg::DEFAULT_DUTY;
            phase_1   <= '0;
            duty_2    <= dab_pkg::DEFAULT_DUTY;
            phase_2   <= '0;
        end else if (load) begin
            enable    <= enable_shadow;
            period    <= period_shadow;
            dead_time <= dead_time_shadow;
            duty_1    <= duty_1_shadow;
            phase_1   <= phase_1_shadow;
            duty_2    <= duty_2_shadow;
            phase_2   <= phase_2_shadow;
        end
    end

endmodule

//--- hdl/modulator_timebase.sv
// Modulator timebase
// Wrap-around period counter with an end-of-period strobe
`timescale 1ns/1ps

module modulator_timebase (
    input  logic            clock,
    input  logic            reset,
    input  logic            enable,
    input  dab_pkg::duty_t  period,
    output dab_pkg::duty_t  count,
    output logic            period_end
);

    logic            running;
    dab_pkg::duty_t  last_count;

    assign last_count = period - 1'b1;

    // Only flagged once the counter has started from zero
    assign period_end = enable && running && (count == last_count);

    // Count holds at zero for the first enabled cycle, then runs
    always_ff @(posedge clock) begin
        if (!reset) begin
            running <= 1'b0;
            count   <= '0;
        end else begin
            running <= enable;
            if (!enable || !running || period_end) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- hdl/pwm_leg.sv
// PWM leg
// Phase-shifted window compare against the timebase with dead-time
// insertion, driving one complementary high/low gate pair
`timescale 1ns/1ps

module pwm_leg (
    input  logic            clock,
    input  logic            reset,
    input  dab_pkg::duty_t  count,
    input  dab_pkg::duty_t  period,
    input  dab_pkg::duty_t  duty,
    input  dab_pkg::duty_t  phase,
    input  dab_pkg::duty_t  dead_time,
    output logic            gate_high,
    output logic            gate_low
);

    logic [16:0]     window_sum;
    logic [16:0]     window_wrapped;
    logic            wraps;
    dab_pkg::duty_t  window_end;
    logic            in_window;
    logic            active_next;
    logic            raw_next;
    logic            active_q;
    logic            raw_q;
    logic            raw_edge;
    dab_pkg::duty_t  dead_count;
    logic            dead_done;

    // Window end taken modulo the period
    assign window_sum     = {1'b0, phase} + {1'b0, duty};
    assign window_wrapped = window_sum - {1'b0, period};
    assign wraps          = window_sum >= {1'b0, period};
    assign window_end     = wraps ? window_wrapped[15:0] : window_sum[15:0];

    assign in_window = wraps ? ((count >= phase) || (count < window_end))
                             : ((count >= phase) && (count < window_end));

    // A zero period means the leg is not configured
    assign active_next = period != '0;
    assign raw_next    = active_next && in_window;

    assign raw_edge  = (raw_next != raw_q) || (active_next != active_q);
    assign dead_done = dead_count >= dead_time;

    // First stage registers the raw drive and times the dead band
    always_ff @(posedge clock) begin
        if (!reset) begin
            active_q   <= 1'b0;
            raw_q      <= 1'b0;
            dead_count <= '0;
        end else begin
            active_q <= active_next;
            raw_q    <= raw_next;
            if (raw_edge) begin
                dead_count <= '0;
            end else if (dead_count != '1) begin
                dead_count <= dead_count + 1'b1;
            end
        end
    end

    // Outgoing gate drops at once, the incoming one waits out the dead band
    always_ff @(posedge clock) begin
        if (!reset) begin
            gate_high <= 1'b0;
            gate_low  <= 1'b0;
        end else begin
            gate_high <= raw_q && dead_done;
            gate_low  <= active_q && !raw_q && dead_done;
        end
    end

endmodule

//--- hdl/dab_modulator_top.sv
// DAB modulator top level
// Processor, register file, shared timebase and one PWM leg per bridge
`timescale 1ns/1ps

module dab_modulator_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            configure,
    input  logic [3:0]      update,
    input  dab_pkg::duty_t  duty_1,
    input  dab_pkg::duty_t  duty_2,
    input  dab_pkg::duty_t  phase_shift_1,
    input  dab_pkg::duty_t  phase_shift_2,
    output logic            done,
    output logic            gate_1_high,
    output logic            gate_1_low,
    output logic            gate_2_high,
    output logic            gate_2_low
);

    // Internal write bus
    logic            write_valid;
    logic            write_ready;
    dab_pkg::addr_t  write_dest;
    dab_pkg::data_t  write_data;

    // Active register values
    logic            enable;
    dab_pkg::duty_t  period;
    dab_pkg::duty_t  dead_time;
    dab_pkg::duty_t  active_duty_1;
    dab_pkg::duty_t  active_phase_1;
    dab_pkg::duty_t  active_duty_2;
    dab_pkg::duty_t  active_phase_2;

    dab_pkg::duty_t  count;
    logic            period_end;

    dab_pre_modulation_processor u_processor (
        .clock         (clock),
        .reset         (reset),
        .configure     (configure),
        .update        (update),
        .duty_1        (duty_1),
        .duty_2        (duty_2),
        .phase_shift_1 (phase_shift_1),
        .phase_shift_2 (phase_shift_2),
        .write_ready   (write_ready),
        .done          (done),
        .write_valid   (write_valid),
        .write_dest    (write_dest),
        .write_data    (write_data)
    );

    modulator_register_file u_register_file (
        .clock       (clock),
        .reset       (reset),
        .write_valid (write_valid),
        .write_dest  (write_dest),
        .write_data  (write_data),
        .period_end  (period_end),
        .write_ready (write_ready),
        .enable      (enable),
        .period      (period),
        .dead_time   (dead_time),
        .duty_1      (active_duty_1),
        .phase_1     (active_phase_1),
        .duty_2      (active_duty_2),
        .phase_2     (active_phase_2)
    );

    modulator_timebase u_timebase (
        .clock      (clock),
        .reset      (reset),
        .enable     (enable),
        .period     (period),
        .count      (count),
        .period_end (period_end)
    );

    pwm_leg u_leg_1 (
        .clock     (clock),
        .reset     (reset),
        .count     (count),
        .period    (period),
        .duty      (active_duty_1),
        .phase     (active_phase_1),
        .dead_time (dead_time),
        .gate_high (gate_1_high),
        .gate_low  (gate_1_low)
    );

    pwm_leg u_leg_2 (
        .clock     (clock),
        .reset     (reset),
        .count     (count),
        .period    (period),
        .duty      (active_duty_2),
        .phase     (active_phase_2),
        .dead_time (dead_time),
        .gate_high (gate_2_high),
        .gate_low  (gate_2_low)
    );

endmodule

//--- testbench/dab_modulator_tb.sv
// DAB modulator testbench
// Applies configure and update requests from a table and measures gate
// widths, dead time and the phase offset between the two bridge legs
`timescale 1ns/1ps

module dab_modulator_tb;

    localparam int ROWS    = 8;
    localparam int TIMEOUT = 400;
    localparam int PERIOD  = int'(dab_pkg::DEFAULT_PERIOD);
    localparam dab_pkg::duty_t DEAD = dab_pkg::DEFAULT_DEAD_TIME;

    logic            clock;
    logic            reset;
    logic            configure;
    logic [3:0]      update;
    dab_pkg::duty_t  duty_1;
    dab_pkg::duty_t  duty_2;
    dab_pkg::duty_t  phase_shift_1;
    dab_pkg::duty_t  phase_shift_2;
    logic            done;
    logic            gate_1_high;
    logic            gate_1_low;
    logic            gate_2_high;
    logic            gate_2_low;

    // Stimulus table with one update request per row
    logic [3:0]      mask_tab [ROWS];
    dab_pkg::duty_t  duty_1_tab [ROWS];
    dab_pkg::duty_t  duty_2_tab [ROWS];
    dab_pkg::duty_t  phase_1_tab [ROWS];
    dab_pkg::duty_t  phase_2_tab [ROWS];

    // Model of the active register values
    dab_pkg::duty_t  model_duty_1;
    dab_pkg::duty_t  model_duty_2;
    dab_pkg::duty_t  model_phase_1;
    dab_pkg::duty_t  model_phase_2;

    integer seed;
    int     cycle = 0;
    int     done_count = 0;
    int     errors = 0;
    int     tests = 0;
    int     failed = 0;
    int     errors_before;

    dab_modulator_top u_dut (
        .clock         (clock),
        .reset         (reset),
        .configure     (configure),
        .update        (update),
        .duty_1        (duty_1),
        .duty_2        (duty_2),
        .phase_shift_1 (phase_shift_1),
        .phase_shift_2 (phase_shift_2),
        .done          (done),
        .gate_1_high   (gate_1_high),
        .gate_1_low    (gate_1_low),
        .gate_2_high   (gate_2_high),
        .gate_2_low    (gate_2_low)
    );

    always begin
        clock = 1'b0;
        #20;
        clock = 1'b1;
        #20;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Watches for shoot-through and counts done pulses on the falling edge
    always @(negedge clock) begin
        if (reset && ((gate_1_high && gate_1_low) || (gate_2_high && gate_2_low))) begin
            $display("ERROR: both gates of one leg are high together at cycle %0d", cycle);
            errors++;
        end
        if (done) begin
            done_count++;
        end
    end

    task automatic finish_run;
        $display("%0d tests run, %0d failed, %0d check errors", tests, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic check_width(input string name, input dab_pkg::duty_t got,
                               input dab_pkg::duty_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end
        errors_before = errors;
    endtask

    task automatic load_row(input int i, input logic [3:0] mask, input int d1, input int d2,
                            input int p1, input int p2);
        mask_tab[i]    = mask;
        duty_1_tab[i]  = dab_pkg::duty_t'(d1);
        duty_2_tab[i]  = dab_pkg::duty_t'(d2);
        phase_1_tab[i] = dab_pkg::duty_t'(p1);
        phase_2_tab[i] = dab_pkg::duty_t'(p2);
    endtask

    // Drives one request cycle just after the rising edge
    task automatic request(input logic cfg, input logic [3:0] mask, input dab_pkg::duty_t d1,
                           input dab_pkg::duty_t d2, input dab_pkg::duty_t p1,
                           input dab_pkg::duty_t p2);
        @(posedge clock);
        #2;
        configure     = cfg;
        update        = mask;
        duty_1        = d1;
        duty_2        = d2;
        phase_shift_1 = p1;
        phase_shift_2 = p2;
        @(posedge clock);
        #2;
        configure = 1'b0;
        update    = 4'b0000;
    endtask

    task automatic wait_done;
        int n;
        n = 0;
        while (done !== 1'b1 && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (done !== 1'b1) begin
            $display("ERROR: no done pulse within %0d cycles", TIMEOUT);
            errors++;
            finish_run();
        end
    endtask

    function automatic logic gate_of(input int leg, input logic high);
        if (leg == 1) begin
            return high ? gate_1_high : gate_1_low;
        end
        return high ? gate_2_high : gate_2_low;
    endfunction

    // Counts cycles until the selected gate reaches the given level
    task automatic count_until(input int leg, input logic high, input logic level,
                               output int n);
        n = 0;
        while (gate_of(leg, high) !== level && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (gate_of(leg, high) !== level) begin
            $display("ERROR: leg %0d gate did not change within %0d cycles", leg, TIMEOUT);
            errors++;
            finish_run();
        end
    endtask

    task automatic measure_leg(input int leg, output dab_pkg::duty_t high_width,
                               output dab_pkg::duty_t low_width, output int rise_at);
        int n;
        @(negedge clock);
        count_until(leg, 1'b1, 1'b0, n);
        count_until(leg, 1'b1, 1'b1, n);
        rise_at = cycle;
        count_until(leg, 1'b1, 1'b0, n);
        high_width = dab_pkg::duty_t'(n);
        count_until(leg, 1'b0, 1'b1, n);
        check_width($sformatf("gate_%0d_low turn-on gap", leg), dab_pkg::duty_t'(n), DEAD);
        count_until(leg, 1'b0, 1'b0, n);
        low_width = dab_pkg::duty_t'(n);
        count_until(leg, 1'b1, 1'b1, n);
        check_width($sformatf("gate_%0d_high turn-on gap", leg), dab_pkg::duty_t'(n), DEAD);
    endtask

    // Both legs are compared with the model and each width loses one dead band
    task automatic check_legs;
        dab_pkg::duty_t high_width;
        dab_pkg::duty_t low_width;
        int rise_1;
        int rise_2;
        int want;
        measure_leg(1, high_width, low_width, rise_1);
        check_width("gate_1_high width", high_width, model_duty_1 - DEAD);
        check_width("gate_1_low width", low_width, PERIOD - model_duty_1 - DEAD);
        measure_leg(2, high_width, low_width, rise_2);
        check_width("gate_2_high width", high_width, model_duty_2 - DEAD);
        check_width("gate_2_low width", low_width, PERIOD - model_duty_2 - DEAD);
        want = ((int'(model_phase_2) - int'(model_phase_1)) % PERIOD + PERIOD) % PERIOD;
        check_width("gate_2_high phase offset",
                    dab_pkg::duty_t'(((rise_2 - rise_1) % PERIOD + PERIOD) % PERIOD),
                    dab_pkg::duty_t'(want));
    endtask

    initial begin
        int start;
        seed          = 90;
        reset         = 1'b0;
        configure     = 1'b0;
        update        = 4'b0000;
        duty_1        = '0;
        duty_2        = '0;
        phase_shift_1 = '0;
        phase_shift_2 = '0;
        errors_before = 0;

        // Masked rows carry values that must not reach the legs
        load_row(0, 4'b1111, 30, 70, 0, 25);
        load_row(1, 4'b0100, 90, 10, 10, 80);
        load_row(2, 4'b0011, 60, 40, 99, 99);
        load_row(3, 4'b1000, 5, 95, 3, 90);
        for (int i = 4; i < ROWS; i++) begin
            load_row(i, 4'($random(seed)) | 4'b0001, 5 + $unsigned($random(seed)) % 91,
                     5 + $unsigned($random(seed)) % 91, $unsigned($random(seed)) % PERIOD,
                     $unsigned($random(seed)) % PERIOD);
        end

        repeat (4) @(posedge clock);
        #2;
        reset = 1'b1;

        repeat (10) begin
            @(negedge clock);
            check_done("done", done, 1'b0);
            check_done("gate_1_high", gate_1_high, 1'b0);
            check_done("gate_1_low", gate_1_low, 1'b0);
            check_done("gate_2_high", gate_2_high, 1'b0);
            check_done("gate_2_low", gate_2_low, 1'b0);
        end
        end_test("reset state");

        start = done_count;
        request(1'b1, 4'b0000, '0, '0, '0, '0);
        wait_done();
        repeat (20) @(negedge clock);
        check_done("single done pulse", done_count == start + 1, 1'b1);
        model_duty_1  = dab_pkg::DEFAULT_DUTY;
        model_duty_2  = dab_pkg::DEFAULT_DUTY;
        model_phase_1 = '0;
        model_phase_2 = '0;
        repeat (2 * PERIOD) @(posedge clock);
        check_legs();
        end_test("configure");

        for (int i = 0; i < ROWS; i++) begin
            request(1'b0, mask_tab[i], duty_1_tab[i], duty_2_tab[i], phase_1_tab[i],
                    phase_2_tab[i]);
            wait_done();
            if (mask_tab[i][0]) model_duty_1 = duty_1_tab[i];
            if (mask_tab[i][1]) model_duty_2 = duty_2_tab[i];
            if (mask_tab[i][2]) model_phase_1 = phase_1_tab[i];
            if (mask_tab[i][3]) model_phase_2 = phase_2_tab[i];
            repeat (2 * PERIOD) @(posedge clock);
            check_legs();
            end_test($sformatf("update row %0d", i));
        end

        start = done_count;
        request(1'b0, 4'b0000, 16'd7, 16'd7, 16'd7, 16'd7);
        repeat (20) @(negedge clock);
        check_done("done", done_count != start, 1'b0);
        check_legs();
        end_test("empty update mask");

        finish_run();
    end

endmodule

//--- files.f
hdl/dab_pkg.sv
hdl/dab_pre_modulation_processor.sv
hdl/modulator_register_file.sv
hdl/modulator_timebase.sv
hdl/pwm_leg.sv
hdl/dab_modulator_top.sv
testbench/dab_modulator_tb.sv

//--- Bender.yml
package:
  name: dab_modulator

sources:
  - hdl/dab_pkg.sv
  - hdl/dab_pre_modulation_processor.sv
  - hdl/modulator_register_file.sv
  - hdl/modulator_timebase.sv
  - hdl/pwm_leg.sv
  - hdl/dab_modulator_top.sv
  - target: simulation
    files:
      - testbench/dab_modulator_tb.sv
